//--- sim.f
design/soc_pkg.sv
design/soc_bus.sv
design/soc_timer.sv
design/gpio_regs.sv
design/gpio_pads.sv
design/soc_top.sv
tb/tb_soc_top.sv

//--- tb/tb_soc_top.sv
// Testbench for the peripheral subsystem top level.
// Plays both bus masters with four-phase req/ack, drives the GPIO pins
// from outside and checks the responses against a register model.
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;

    // ack is first seen high on the third falling edge after req
    localparam int ACK_NEG     = 3;
    localparam int TIMEOUT_CYC = 4000;

    logic                               clk;
    logic                               arst_n_i;
    logic [soc_pkg::DATA_W-1:0]         m0_addr_i, m0_wdata_i, m0_rdata_o;
    logic                               m0_we_i, m0_req_i, m0_ack_o;
    logic [soc_pkg::DATA_W-1:0]         m1_addr_i, m1_wdata_i, m1_rdata_o;
    logic                               m1_we_i, m1_req_i, m1_ack_o;
    logic                               timer_irq_o;
    wire  [soc_pkg::NUM_GPIO-1:0]       gpio_io;
    logic [soc_pkg::NUM_GPIO-1:0]       pin_drv;
    logic [soc_pkg::NUM_GPIO-1:0]       pin_oe;

    // register model
    logic [1:0]                         sh_tmr_ctrl;
    logic                               sh_pend;
    logic [soc_pkg::DATA_W-1:0]         sh_tmr_cmp;
    logic [2*soc_pkg::NUM_GPIO-1:0]     sh_mode;
    logic [soc_pkg::NUM_GPIO-1:0]       sh_out;

    logic [31:0] rng_q;
    int          cyc;
    int          n_checks;
    int          n_errors;
    int          ack_lat[2];
    int          ack_cyc[2];
    int          done_cyc[2];

    soc_top DUT (
        .clk         ( clk         ),
        .arst_n_i    ( arst_n_i    ),
        .m0_addr_i   ( m0_addr_i   ),
        .m0_we_i     ( m0_we_i     ),
        .m0_wdata_i  ( m0_wdata_i  ),
        .m0_req_i    ( m0_req_i    ),
        .m0_rdata_o  ( m0_rdata_o  ),
        .m0_ack_o    ( m0_ack_o    ),
        .m1_addr_i   ( m1_addr_i   ),
        .m1_we_i     ( m1_we_i     ),
        .m1_wdata_i  ( m1_wdata_i  ),
        .m1_req_i    ( m1_req_i    ),
        .m1_rdata_o  ( m1_rdata_o  ),
        .m1_ack_o    ( m1_ack_o    ),
        .timer_irq_o ( timer_irq_o ),
        .gpio_io     ( gpio_io     )
    );

    // external pin drivers
    for (genvar i = 0; i < soc_pkg::NUM_GPIO; i++) begin : g_pin_drv
        assign gpio_io[i] = pin_oe[i] ? pin_drv[i] : 1'bz;
    end

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC) begin
            $display("timeout: the test sequence did not finish within %0d cycles", cyc);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_q;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_q = x;
        return x;
    endfunction

    function automatic soc_pkg::bus_addr_t mk_addr(input logic [3:0] slv,
                                                    input logic [27:0] ofs);
        soc_pkg::bus_addr_t a;
        a.f.slv    = slv;
        a.f.offset = ofs;
        return a;
    endfunction

    // expected read data for any address
    function automatic logic [31:0] soc_expect(input soc_pkg::bus_addr_t a);
        logic [31:0] r;
        r = '0;
        if (a.f.slv == soc_pkg::SLV_TIMER) begin
            // running counter is checked by range, not here
            case (a.f.offset)
                soc_pkg::TMR_CTRL: r = {28'd0, sh_pend, 1'b0, sh_tmr_ctrl};
                soc_pkg::TMR_CMP:  r = sh_tmr_cmp;
                default:           r = '0;
            endcase
        end else if (a.f.slv == soc_pkg::SLV_GPIO) begin
            if (a.f.offset == soc_pkg::GPIO_CTRL) begin
                r = sh_mode;
            end else if (a.f.offset == soc_pkg::GPIO_DATA) begin
                for (int i = 0; i < soc_pkg::NUM_GPIO; i++) begin
                    case (sh_mode[2*i +: 2])
                        soc_pkg::GPIO_MODE_OUT: r[i] = sh_out[i];
                        soc_pkg::GPIO_MODE_IN:  r[i] = pin_oe[i] ? pin_drv[i] : 1'bx;
                        default:                r[i] = 1'b0;
                    endcase
                end
            end
        end
        return r;
    endfunction

    // output pins show their data bit, everything else floats
    function automatic logic [15:0] pins_expect();
        logic [15:0] p;
        for (int i = 0; i < soc_pkg::NUM_GPIO; i++) begin
            p[i] = (sh_mode[2*i +: 2] == soc_pkg::GPIO_MODE_OUT) ? sh_out[i] : 1'bz;
        end
        return p;
    endfunction

    task automatic model_write(input soc_pkg::bus_addr_t a, input logic [31:0] d);
        if (a.f.slv == soc_pkg::SLV_TIMER && a.f.offset == soc_pkg::TMR_CTRL) begin
            sh_tmr_ctrl = d[1:0];
            if (d[2]) begin
                sh_pend = 1'b0;
            end
        end
        if (a.f.slv == soc_pkg::SLV_TIMER && a.f.offset == soc_pkg::TMR_CMP) begin
            sh_tmr_cmp = d;
        end
        if (a.f.slv == soc_pkg::SLV_GPIO && a.f.offset == soc_pkg::GPIO_CTRL) begin
            sh_mode = d;
        end
        if (a.f.slv == soc_pkg::SLV_GPIO && a.f.offset == soc_pkg::GPIO_DATA) begin
            sh_out = d[15:0];
        end
    endtask

    task automatic check_data(input string name, input logic [soc_pkg::DATA_W-1:0] got,
                              input logic [soc_pkg::DATA_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pins(input string name, input logic [soc_pkg::NUM_GPIO-1:0] got,
                              input logic [soc_pkg::NUM_GPIO-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic drive_master(input bit mst, input logic [31:0] addr, input logic we,
                                input logic [31:0] wdata, input logic req);
        if (mst) begin
            m1_addr_i  = addr;
            m1_we_i    = we;
            m1_wdata_i = wdata;
            m1_req_i   = req;
        end else begin
            m0_addr_i  = addr;
            m0_we_i    = we;
            m0_wdata_i = wdata;
            m0_req_i   = req;
        end
    endtask

    // ------------------------------------------------------------
    // four-phase master access
    // ------------------------------------------------------------
    task automatic bus_access(input bit mst, input soc_pkg::bus_addr_t a, input logic we,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        n = 0;
        @(negedge clk);
        drive_master(mst, a.raw, we, wdata, 1'b1);
        do begin
            @(negedge clk);
            n++;
        end while (!(mst ? m1_ack_o : m0_ack_o));
        rdata         = mst ? m1_rdata_o : m0_rdata_o;
        ack_lat[mst]  = n;
        ack_cyc[mst]  = cyc;
        drive_master(mst, a.raw, we, wdata, 1'b0);
        @(negedge clk);
        check_bit(mst ? "m1_ack_o" : "m0_ack_o", mst ? m1_ack_o : m0_ack_o, 1'b0);
        done_cyc[mst] = cyc;
    endtask

    task automatic bus_write(input bit mst, input soc_pkg::bus_addr_t a, input logic [31:0] d);
        logic [31:0] unused;
        bus_access(mst, a, 1'b1, d, unused);
        model_write(a, d);
    endtask

    task automatic bus_read(input bit mst, input soc_pkg::bus_addr_t a, output logic [31:0] d);
        bus_access(mst, a, 1'b0, '0, d);
    endtask

    task automatic test_done(input string name, input int err_before);
        $display("%-14s %0d errors", name, n_errors - err_before);
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic test_reset();
        int e;
        e = n_errors;
        check_bit("m0_ack_o", m0_ack_o, 1'b0);
        check_bit("m1_ack_o", m1_ack_o, 1'b0);
        check_bit("timer_irq_o", timer_irq_o, 1'b0);
        check_pins("drive_en", DUT.u_gpio_pads.drive_en, '0);
        check_pins("gpio_io", gpio_io, {soc_pkg::NUM_GPIO{1'bz}});
        test_done("reset", e);
    endtask

    task automatic test_round_trip();
        soc_pkg::bus_addr_t a[3];
        logic [31:0]        r;
        int                 e;
        e    = n_errors;
        a[0] = mk_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_CMP);
        a[1] = mk_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_CTRL);
        a[2] = mk_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_DATA);
        for (int k = 0; k < 3; k++) begin
            // all pins out so the data word reads back whole
            if (k == 2) begin
                bus_write(1'b0, a[1], 32'h5555_5555);
            end
            for (int i = 0; i < 4; i++) begin
                bus_write(i[0], a[k], xorshift32());
                check_data("req to ack falling edges", ack_lat[i[0]], ACK_NEG);
                bus_read(!i[0], a[k], r);
                check_data("req to ack falling edges", ack_lat[!i[0]], ACK_NEG);
                check_data("rdata", r, soc_expect(a[k]));
            end
        end
        // unmapped nibbles, write dropped and read zero
        bus_write(1'b0, mk_addr(4'h3, 'h0), xorshift32());
        bus_read(1'b1, mk_addr(4'h3, 'h0), r);
        check_data("unmapped rdata", r, soc_expect(mk_addr(4'h3, 'h0)));
        bus_read(1'b0, mk_addr(4'h0, 'h4), r);
        check_data("unmapped rdata", r, 32'h0);
        test_done("round trip", e);
    endtask

    task automatic test_arbitration();
        soc_pkg::bus_addr_t a;
        logic [31:0]        v;
        logic [31:0]        r;
        int                 e;
        e = n_errors;
        a = mk_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_CMP);
        v = xorshift32();
        fork
            bus_write(1'b0, a, v);
            bus_read(1'b1, a, r);
        join
        check_data("m0 req to ack falling edges", ack_lat[0], ACK_NEG);
        n_checks++;
        if (ack_cyc[1] <= done_cyc[0]) begin
            n_errors++;
            $display("m1 was acknowledged before the m0 handshake had finished");
        end
        check_data("m1_rdata_o", r, soc_expect(a));
        test_done("arbitration", e);
    endtask

    task automatic test_gpio_out();
        int e;
        e = n_errors;
        // pins 0-7 out, 8-11 in, 12-13 mode 00, 14-15 mode 11
        bus_write(1'b0, mk_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_CTRL), 32'hF0AA_5555);
        bus_write(1'b1, mk_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_DATA), xorshift32());
        check_pins("gpio_io", gpio_io, pins_expect());
        test_done("gpio out", e);
    endtask

    task automatic test_gpio_in();
        soc_pkg::bus_addr_t a;
        logic [31:0]        v;
        logic [31:0]        r;
        int                 e;
        e = n_errors;
        a = mk_addr(soc_pkg::SLV_GPIO, soc_pkg::GPIO_DATA);
        for (int i = 0; i < 3; i++) begin
            v = xorshift32();
            @(negedge clk);
            pin_drv = v[15:0];
            pin_oe  = 16'hFF00;
            repeat (3) @(negedge clk);
            bus_read(i[0], a, r);
            check_data("GPIO_DATA", r, soc_expect(a));
        end
        pin_oe = '0;
        test_done("gpio in", e);
    endtask

    task automatic test_timer();
        soc_pkg::bus_addr_t a_ctrl;
        logic [31:0]        r;
        int                 n;
        int                 e;
        e      = n_errors;
        n      = 0;
        a_ctrl = mk_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_CTRL);
        bus_write(1'b0, mk_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_VALUE), 32'd0);
        bus_write(1'b0, mk_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_CMP), 32'd20);
        bus_write(1'b0, a_ctrl, 32'h3);
        while (!timer_irq_o && n < 25) begin
            @(negedge clk);
            n++;
        end
        n_checks++;
        if (!timer_irq_o) begin
            n_errors++;
            $display("timer_irq_o did not rise within 25 cycles of enabling the timer");
        end
        sh_pend = 1'b1;
        for (int i = 0; i < 4; i++) begin
            bus_read(1'b1, mk_addr(soc_pkg::SLV_TIMER, soc_pkg::TMR_VALUE), r);
            n_checks++;
            if (r > 32'd20) begin
                n_errors++;
                $display("** Error at %0t: TMR_VALUE = %0d, expected 0 to 20", $time, r);
            end
        end
        bus_read(1'b0, a_ctrl, r);
        check_data("TMR_CTRL", r, soc_expect(a_ctrl));
        // clear pending and stop the counter, irq stays enabled
        bus_write(1'b1, a_ctrl, 32'h6);
        check_bit("timer_irq_o", timer_irq_o, 1'b0);
        bus_read(1'b0, a_ctrl, r);
        check_data("TMR_CTRL", r, soc_expect(a_ctrl));
        test_done("timer", e);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        pin_drv     = '0;
        pin_oe      = '0;
        rng_q       = 32'd64;
        cyc         = 0;
        n_checks    = 0;
        n_errors    = 0;
        sh_tmr_ctrl = '0;
        sh_pend     = 1'b0;
        sh_tmr_cmp  = '0;
        sh_mode     = '0;
        sh_out      = '0;
        drive_master(1'b0, '0, 1'b0, '0, 1'b0);
        drive_master(1'b1, '0, 1'b0, '0, 1'b0);
        repeat (8) @(posedge clk);
        @(negedge clk);
        test_reset();
        arst_n_i = 1'b1;

        test_round_trip();
        test_arbitration();
        test_gpio_out();
        test_gpio_in();
        test_timer();

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/soc_top.sv
// Top level of the peripheral subsystem.
// Two masters share the fabric, which reaches the timer and the GPIO
// register block; the GPIO pads sit beside the registers at the pins.
`timescale 1ns/1ps
`default_nettype none

module soc_top (
    input  logic                       clk,
    input  logic                       arst_n_i,

    input  logic [soc_pkg::DATA_W-1:0] m0_addr_i,
    input  logic                       m0_we_i,
    input  logic [soc_pkg::DATA_W-1:0] m0_wdata_i,
    input  logic                       m0_req_i,
    output logic [soc_pkg::DATA_W-1:0] m0_rdata_o,
    output logic                       m0_ack_o,

    input  logic [soc_pkg::DATA_W-1:0] m1_addr_i,
    input  logic                       m1_we_i,
    input  logic [soc_pkg::DATA_W-1:0] m1_wdata_i,
    input  logic                       m1_req_i,
    output logic [soc_pkg::DATA_W-1:0] m1_rdata_o,
    output logic                       m1_ack_o,

    output logic                       timer_irq_o,
    inout  wire  [soc_pkg::NUM_GPIO-1:0] gpio_io
);

    // slave side of the fabric
    logic                           tmr_sel;
    logic                           gpio_sel;
    logic                           slv_we;
    logic [soc_pkg::OFS_W-1:0]      slv_offset;
    logic [soc_pkg::DATA_W-1:0]     slv_wdata;
    logic [soc_pkg::DATA_W-1:0]     tmr_rdata;
    logic [soc_pkg::DATA_W-1:0]     gpio_rdata;

    // gpio registers to pads
    logic [2*soc_pkg::NUM_GPIO-1:0] gpio_mode;
    logic [soc_pkg::NUM_GPIO-1:0]   gpio_out;
    logic [soc_pkg::NUM_GPIO-1:0]   gpio_in;

    soc_bus u_bus (
        .clk          ( clk        ),
        .arst_n_i     ( arst_n_i   ),
        .m0_addr_i    ( m0_addr_i  ),
        .m0_we_i      ( m0_we_i    ),
        .m0_wdata_i   ( m0_wdata_i ),
        .m0_req_i     ( m0_req_i   ),
        .m0_rdata_o   ( m0_rdata_o ),
        .m0_ack_o     ( m0_ack_o   ),
        .m1_addr_i    ( m1_addr_i  ),
        .m1_we_i      ( m1_we_i    ),
        .m1_wdata_i   ( m1_wdata_i ),
        .m1_req_i     ( m1_req_i   ),
        .m1_rdata_o   ( m1_rdata_o ),
        .m1_ack_o     ( m1_ack_o   ),
        .tmr_sel_o    ( tmr_sel    ),
        .gpio_sel_o   ( gpio_sel   ),
        .slv_we_o     ( slv_we     ),
        .slv_offset_o ( slv_offset ),
        .slv_wdata_o  ( slv_wdata  ),
        .tmr_rdata_i  ( tmr_rdata  ),
        .gpio_rdata_i ( gpio_rdata )
    );

    soc_timer u_timer (
        .clk      ( clk         ),
        .arst_n_i ( arst_n_i    ),
        .sel_i    ( tmr_sel     ),
        .we_i     ( slv_we      ),
        .offset_i ( slv_offset  ),
        .wdata_i  ( slv_wdata   ),
        .rdata_o  ( tmr_rdata   ),
        .irq_o    ( timer_irq_o )
    );

    gpio_regs u_gpio_regs (
        .clk        ( clk        ),
        .arst_n_i   ( arst_n_i   ),
        .sel_i      ( gpio_sel   ),
        .we_i       ( slv_we     ),
        .offset_i   ( slv_offset ),
        .wdata_i    ( slv_wdata  ),
        .rdata_o    ( gpio_rdata ),
        .mode_o     ( gpio_mode  ),
        .out_data_o ( gpio_out   ),
        .pin_data_i ( gpio_in    )
    );

    gpio_pads u_gpio_pads (
        .clk        ( clk       ),
        .arst_n_i   ( arst_n_i  ),
        .mode_i     ( gpio_mode ),
        .out_data_i ( gpio_out  ),
        .gpio_io    ( gpio_io   ),
        .pin_data_o ( gpio_in   )
    );

endmodule

`default_nettype wire

//--- design/gpio_pads.sv
// Pad logic for the GPIO pins.
// Drives a pin only in output mode, otherwise releases it to Z, and
// passes input-mode pins through a two-flop synchronizer.
`timescale 1ns/1ps
`default_nettype none

module gpio_pads (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic [2*soc_pkg::NUM_GPIO-1:0] mode_i,
    input  logic [soc_pkg::NUM_GPIO-1:0]   out_data_i,
    inout  wire  [soc_pkg::NUM_GPIO-1:0]   gpio_io,
    output logic [soc_pkg::NUM_GPIO-1:0]   pin_data_o
);

    logic [soc_pkg::NUM_GPIO-1:0] drive_en;
    logic [soc_pkg::NUM_GPIO-1:0] in_en;
    logic [soc_pkg::NUM_GPIO-1:0] sync1_q;
    logic [soc_pkg::NUM_GPIO-1:0] sync2_q;

    for (genvar i = 0; i < soc_pkg::NUM_GPIO; i++) begin : g_pin
        assign drive_en[i] = (mode_i[2*i +: 2] == soc_pkg::GPIO_MODE_OUT);
        assign in_en[i]    = (mode_i[2*i +: 2] == soc_pkg::GPIO_MODE_IN);
        assign gpio_io[i]  = drive_en[i] ? out_data_i[i] : 1'bz;
    end

    // two-flop synchronizer on the raw pad levels
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gpio_io;
            sync2_q <= sync1_q;
        end
    end

    // pins that are off or driving read as zero here
    assign pin_data_o = sync2_q & in_en;

endmodule

`default_nettype wire

//--- design/gpio_regs.sv
// GPIO register block: per-pin mode word and output data word.
// Sits beside the pad logic, feeding it mode and data and reading
// back the synchronized input pins for GPIO_DATA reads.
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           sel_i,
    input  logic                           we_i,
    input  logic [soc_pkg::OFS_W-1:0]      offset_i,
    input  logic [soc_pkg::DATA_W-1:0]     wdata_i,
    output logic [soc_pkg::DATA_W-1:0]     rdata_o,
    output logic [2*soc_pkg::NUM_GPIO-1:0] mode_o,
    output logic [soc_pkg::NUM_GPIO-1:0]   out_data_o,
    input  logic [soc_pkg::NUM_GPIO-1:0]   pin_data_i
);

    logic [2*soc_pkg::NUM_GPIO-1:0] mode_q;
    logic [soc_pkg::NUM_GPIO-1:0]   out_q;
    logic [soc_pkg::NUM_GPIO-1:0]   data_mix;
    logic [soc_pkg::DATA_W-1:0]     rdata_q;

    // reset leaves every pin off
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mode_q <= '0;
            out_q  <= '0;
        end else if (sel_i && we_i) begin
            if (offset_i == soc_pkg::GPIO_CTRL) begin
                mode_q <= wdata_i;
            end
            if (offset_i == soc_pkg::GPIO_DATA) begin
                out_q <= wdata_i[soc_pkg::NUM_GPIO-1:0];
            end
        end
    end

    // output pins read their own data bit, the rest come from the pads
    always_comb begin
        for (int i = 0; i < soc_pkg::NUM_GPIO; i++) begin
            if (mode_q[2*i +: 2] == soc_pkg::GPIO_MODE_OUT) begin
                data_mix[i] = out_q[i];
            end else begin
                data_mix[i] = pin_data_i[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_i) begin
            case (offset_i)
                soc_pkg::GPIO_CTRL: rdata_q <= mode_q;
                soc_pkg::GPIO_DATA: rdata_q <= {{(soc_pkg::DATA_W - soc_pkg::NUM_GPIO){1'b0}},
                                                data_mix};
                default:            rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o    = rdata_q;
    assign mode_o     = mode_q;
    assign out_data_o = out_q;

endmodule

`default_nettype wire

//--- design/soc_timer.sv
// Timer slave with control, counter and compare registers.
// The counter wraps to zero after reaching compare and latches a
// pending flag, which raises the interrupt when enabled in ctrl.
`timescale 1ns/1ps
`default_nettype none

module soc_timer (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       sel_i,
    input  logic                       we_i,
    input  logic [soc_pkg::OFS_W-1:0]  offset_i,
    input  logic [soc_pkg::DATA_W-1:0] wdata_i,
    output logic [soc_pkg::DATA_W-1:0] rdata_o,
    output logic                       irq_o
);

    // ctrl bit 0 counts, bit 1 enables the interrupt
    logic [1:0]                 ctrl_q;
    logic [soc_pkg::DATA_W-1:0] value_q;
    logic [soc_pkg::DATA_W-1:0] cmp_q;
    logic                       pending_q;
    logic [soc_pkg::DATA_W-1:0] rdata_q;
    logic                       wr;
    logic                       wrap;

    assign wr = sel_i && we_i;
    // greater-than also wraps, so a lowered compare recovers at once
    assign wrap = (value_q >= cmp_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q    <= '0;
            value_q   <= '0;
            cmp_q     <= '0;
            pending_q <= 1'b0;
        end else begin
            if (wr && offset_i == soc_pkg::TMR_CTRL) begin
                ctrl_q <= wdata_i[1:0];
            end
            if (wr && offset_i == soc_pkg::TMR_CMP) begin
                cmp_q <= wdata_i;
            end
            if (wr && offset_i == soc_pkg::TMR_VALUE) begin
                value_q <= wdata_i;
            end else if (ctrl_q[0]) begin
                value_q <= wrap ? '0 : value_q + 1'b1;
            end
            // clear bit is write-only
            if (wr && offset_i == soc_pkg::TMR_CTRL && wdata_i[2]) begin
                pending_q <= 1'b0;
            end else if (ctrl_q[0] && wrap) begin
                pending_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_i) begin
            case (offset_i)
                soc_pkg::TMR_CTRL:  rdata_q <= {28'd0, pending_q, 1'b0, ctrl_q};
                soc_pkg::TMR_VALUE: rdata_q <= value_q;
                soc_pkg::TMR_CMP:   rdata_q <= cmp_q;
                default:            rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_q;
    assign irq_o   = pending_q && ctrl_q[1];

    // counter stays in range once a register write has settled
    a_value_range: assert property (@(posedge clk) disable iff (!arst_n_i)
        (ctrl_q[0] && !$past(wr)) |-> (value_q <= cmp_q));

endmodule

`default_nettype wire

//--- design/soc_bus.sv
// Shared fabric for two masters and two slaves.
// Grants one master at a time (m0 wins ties), decodes the top address
// nibble, pulses the slave select for one cycle and returns the read
// data with a four-phase req/ack handshake.
`timescale 1ns/1ps
`default_nettype none

module soc_bus (
    input  logic                       clk,
    input  logic                       arst_n_i,

    input  logic [soc_pkg::DATA_W-1:0] m0_addr_i,
    input  logic                       m0_we_i,
    input  logic [soc_pkg::DATA_W-1:0] m0_wdata_i,
    input  logic                       m0_req_i,
    output logic [soc_pkg::DATA_W-1:0] m0_rdata_o,
    output logic                       m0_ack_o,

    input  logic [soc_pkg::DATA_W-1:0] m1_addr_i,
    input  logic                       m1_we_i,
    input  logic [soc_pkg::DATA_W-1:0] m1_wdata_i,
    input  logic                       m1_req_i,
    output logic [soc_pkg::DATA_W-1:0] m1_rdata_o,
    output logic                       m1_ack_o,

    output logic                       tmr_sel_o,
    output logic                       gpio_sel_o,
    output logic                       slv_we_o,
    output logic [soc_pkg::OFS_W-1:0]  slv_offset_o,
    output logic [soc_pkg::DATA_W-1:0] slv_wdata_o,
    input  logic [soc_pkg::DATA_W-1:0] tmr_rdata_i,
    input  logic [soc_pkg::DATA_W-1:0] gpio_rdata_i
);

    logic [1:0]                 state_q;
    logic                       grant_q;
    logic                       issue_q;
    soc_pkg::bus_addr_t         addr_q;
    logic                       we_q;
    logic [soc_pkg::DATA_W-1:0] wdata_q;
    logic [soc_pkg::DATA_W-1:0] rdata_q;
    logic                       hit_tmr;
    logic                       hit_gpio;
    logic                       req_gnt;

    assign hit_tmr  = (addr_q.f.slv == soc_pkg::SLV_TIMER);
    assign hit_gpio = (addr_q.f.slv == soc_pkg::SLV_GPIO);
    assign req_gnt  = grant_q ? m1_req_i : m0_req_i;

    // ------------------------------------------------------------
    // controller
    // ------------------------------------------------------------
    // access takes a select cycle and a data return cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= soc_pkg::BUS_IDLE;
            grant_q <= 1'b0;
            issue_q <= 1'b0;
        end else begin
            case (state_q)
                soc_pkg::BUS_IDLE: begin
                    if (m0_req_i || m1_req_i) begin
                        state_q <= soc_pkg::BUS_ACCESS;
                        grant_q <= !m0_req_i;
                        issue_q <= 1'b1;
                    end
                end
                soc_pkg::BUS_ACCESS: begin
                    if (issue_q) begin
                        issue_q <= 1'b0;
                    end else begin
                        state_q <= soc_pkg::BUS_ACK;
                    end
                end
                soc_pkg::BUS_ACK: begin
                    // held until the granted master lets go of req
                    if (!req_gnt) begin
                        state_q <= soc_pkg::BUS_IDLE;
                    end
                end
                default: state_q <= soc_pkg::BUS_IDLE;
            endcase
        end
    end

    // latch the request of whoever is about to win
    always_ff @(posedge clk) begin
        if (state_q == soc_pkg::BUS_IDLE) begin
            addr_q.raw <= m0_req_i ? m0_addr_i  : m1_addr_i;
            we_q       <= m0_req_i ? m0_we_i    : m1_we_i;
            wdata_q    <= m0_req_i ? m0_wdata_i : m1_wdata_i;
        end
        if (state_q == soc_pkg::BUS_ACCESS && !issue_q) begin
            // unmapped reads come back as zero
            if (hit_tmr) begin
                rdata_q <= tmr_rdata_i;
            end else if (hit_gpio) begin
                rdata_q <= gpio_rdata_i;
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign tmr_sel_o    = issue_q && hit_tmr;
    assign gpio_sel_o   = issue_q && hit_gpio;
    assign slv_we_o     = we_q;
    assign slv_offset_o = addr_q.f.offset;
    assign slv_wdata_o  = wdata_q;

    assign m0_ack_o   = (state_q == soc_pkg::BUS_ACK) && !grant_q;
    assign m1_ack_o   = (state_q == soc_pkg::BUS_ACK) && grant_q;
    assign m0_rdata_o = rdata_q;
    assign m1_rdata_o = rdata_q;

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    // ack must follow a dropped req within one edge
    a_m0_ack_drop: assert property (@(posedge clk) disable iff (!arst_n_i)
        (!m0_req_i && $past(!m0_req_i)) |-> !m0_ack_o);

    a_m1_ack_drop: assert property (@(posedge clk) disable iff (!arst_n_i)
        (!m1_req_i && $past(!m1_req_i)) |-> !m1_ack_o);

endmodule

`default_nettype wire

//--- design/soc_pkg.sv
// Shared constants and types for the peripheral subsystem.
// Holds the address map, the register offsets, the GPIO mode codes
// and the bus address layout used by the fabric and the slaves.
`default_nettype none

package soc_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int DATA_W   = 32;
    localparam int NUM_GPIO = 16;
    localparam int SEL_W    = 4;
    localparam int OFS_W    = DATA_W - SEL_W;

    // slave select nibble, everything else is unmapped
    localparam logic [SEL_W-1:0] SLV_TIMER = 4'h1;
    localparam logic [SEL_W-1:0] SLV_GPIO  = 4'h2;

    // timer registers
    localparam logic [OFS_W-1:0] TMR_CTRL  = 'h0;
    localparam logic [OFS_W-1:0] TMR_VALUE = 'h4;
    localparam logic [OFS_W-1:0] TMR_CMP   = 'h8;

    // gpio registers
    localparam logic [OFS_W-1:0] GPIO_CTRL = 'h0;
    localparam logic [OFS_W-1:0] GPIO_DATA = 'h4;

    // per pin mode field, 00 and 11 leave the pin off
    localparam logic [1:0] GPIO_MODE_OUT = 2'b01;
    localparam logic [1:0] GPIO_MODE_IN  = 2'b10;

    // fabric controller states
    localparam logic [1:0] BUS_IDLE   = 2'd0;
    localparam logic [1:0] BUS_ACCESS = 2'd1;
    localparam logic [1:0] BUS_ACK    = 2'd2;

    // bus address, seen as a raw word or as select plus offset
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic [SEL_W-1:0] slv;
            logic [OFS_W-1:0] offset;
        } f;
    } bus_addr_t;

endpackage

`default_nettype wire
